/* design/mul_pkg.sv */
// coefficient multiplier package with datapath widths and the flow and grant encodings
package mul_pkg;

    // sample operand from the per-flow stream
    localparam int op_a_width = 18;

    // coefficient taken from the configuration word
    localparam int coeff_width = 9;

    // row and column counts of one block
    localparam int size_width = 7;

    // full signed product, op_a_width + coeff_width
    localparam int prod_width = 27;

    // state of a single flow
    typedef enum logic
    {
        // waiting for a configuration word
        FLOW_IDLE = 1'b0,
        // multiplying the samples of a block
        FLOW_WORK = 1'b1
    } flow_state_e;

    // action granted by the arbiter in one cycle
    typedef enum logic
    {
        // take a configuration word
        GRANT_LOAD = 1'b0,
        // multiply one sample
        GRANT_MUL  = 1'b1
    } grant_kind_e;

endpackage

/* design/flow_arbiter.sv */
// fixed-priority flow arbiter selecting one load or multiply action per cycle
module flow_arbiter #(
    parameter int num_flows = 2,
    localparam int tag_width = $clog2(num_flows)
) (
    input  logic [num_flows-1:0]  cfg_empty,
    input  logic [num_flows-1:0]  op_a_empty,
    input  logic [num_flows-1:0]  prod_full,
    input  logic [num_flows-1:0]  flow_busy,
    output logic                  grant_valid,
    output logic [tag_width-1:0]  grant_tag,
    output mul_pkg::grant_kind_e  grant_kind,
    output logic [num_flows-1:0]  cfg_read,
    output logic [num_flows-1:0]  op_a_read
);

    logic [num_flows-1:0] eligible;

    // a flow can move if idle with a config waiting,
    // or busy with a sample and room in its output queue
    always_comb
    begin
        for (int f = 0; f < num_flows; f++)
        begin
            eligible[f] = (!flow_busy[f] && !cfg_empty[f]) ||
                          (flow_busy[f] && !op_a_empty[f] && !prod_full[f]);
        end
    end

    // lowest index wins, so scan downward and let the last hit stand
    always_comb
    begin
        grant_valid = 1'b0;
        grant_tag   = '0;
        for (int f = num_flows - 1; f >= 0; f--)
        begin
            if (eligible[f])
            begin
                grant_valid = 1'b1;
                grant_tag   = tag_width'(f);
            end
        end
    end

    // busy flows multiply, idle flows load
    always_comb
    begin
        if (flow_busy[grant_tag])
        begin
            grant_kind = mul_pkg::GRANT_MUL;
        end
        else
        begin
            grant_kind = mul_pkg::GRANT_LOAD;
        end
    end

    // only the granted flow gets a strobe, on the queue its action needs
    always_comb
    begin
        cfg_read  = '0;
        op_a_read = '0;
        if (grant_valid)
        begin
            if (grant_kind == mul_pkg::GRANT_LOAD)
            begin
                cfg_read[grant_tag] = 1'b1;
            end
            else
            begin
                op_a_read[grant_tag] = 1'b1;
            end
        end
    end

endmodule

/* design/flow_context.sv */
// per-flow context store holding state, coefficient, block sizes and position counters
module flow_context #(
    parameter int num_flows = 2,
    localparam int tag_width = $clog2(num_flows)
) (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    grant_valid,
    input  logic [tag_width-1:0]                    grant_tag,
    input  mul_pkg::grant_kind_e                    grant_kind,
    input  logic signed [mul_pkg::coeff_width-1:0]  cfg_coeff [num_flows],
    input  logic [mul_pkg::size_width-1:0]          cfg_rows [num_flows],
    input  logic [mul_pkg::size_width-1:0]          cfg_cols [num_flows],
    output logic [num_flows-1:0]                    flow_busy,
    output logic signed [mul_pkg::coeff_width-1:0]  sel_coeff,
    output logic                                    sel_last
);

    mul_pkg::flow_state_e                    state_q   [num_flows];
    logic signed [mul_pkg::coeff_width-1:0]  coeff_q   [num_flows];
    logic [mul_pkg::size_width-1:0]          rows_q    [num_flows];
    logic [mul_pkg::size_width-1:0]          cols_q    [num_flows];
    logic [mul_pkg::size_width-1:0]          col_cnt_q [num_flows];
    logic [mul_pkg::size_width-1:0]          row_cnt_q [num_flows];

    logic do_load;
    logic do_mul;
    logic col_wrap;
    logic row_wrap;

    assign do_load = grant_valid && (grant_kind == mul_pkg::GRANT_LOAD);
    assign do_mul  = grant_valid && (grant_kind == mul_pkg::GRANT_MUL);

    always_comb
    begin
        for (int f = 0; f < num_flows; f++)
        begin
            flow_busy[f] = (state_q[f] == mul_pkg::FLOW_WORK);
        end
    end

    // position of the granted flow inside its block
    assign col_wrap = (col_cnt_q[grant_tag] == cols_q[grant_tag] - mul_pkg::size_width'(1));
    assign row_wrap = (row_cnt_q[grant_tag] == rows_q[grant_tag] - mul_pkg::size_width'(1));

    assign sel_coeff = coeff_q[grant_tag];
    // last column of the last row ends the block
    assign sel_last  = col_wrap && row_wrap;

    // configuration fields, written only on a load
    always_ff @(posedge clk)
    begin
        if (do_load)
        begin
            coeff_q[grant_tag] <= cfg_coeff[grant_tag];
            rows_q[grant_tag]  <= cfg_rows[grant_tag];
            cols_q[grant_tag]  <= cfg_cols[grant_tag];
        end
    end

    // flow state and counters
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int f = 0; f < num_flows; f++)
            begin
                state_q[f]   <= mul_pkg::FLOW_IDLE;
                col_cnt_q[f] <= '0;
                row_cnt_q[f] <= '0;
            end
        end
        else if (do_load)
        begin
            state_q[grant_tag]   <= mul_pkg::FLOW_WORK;
            col_cnt_q[grant_tag] <= '0;
            row_cnt_q[grant_tag] <= '0;
        end
        else if (do_mul)
        begin
            if (!col_wrap)
            begin
                col_cnt_q[grant_tag] <= col_cnt_q[grant_tag] + mul_pkg::size_width'(1);
            end
            else
            begin
                col_cnt_q[grant_tag] <= '0;
                if (!row_wrap)
                begin
                    row_cnt_q[grant_tag] <= row_cnt_q[grant_tag] + mul_pkg::size_width'(1);
                end
                else
                begin
                    // block done, wait for the next configuration
                    row_cnt_q[grant_tag] <= '0;
                    state_q[grant_tag]   <= mul_pkg::FLOW_IDLE;
                end
            end
        end
    end

endmodule

/* design/product_unit.sv */
// shared signed multiplier producing the tagged product write of the granted flow
module product_unit #(
    parameter int num_flows = 2,
    localparam int tag_width = $clog2(num_flows)
) (
    input  logic                                    grant_valid,
    input  logic [tag_width-1:0]                    grant_tag,
    input  mul_pkg::grant_kind_e                    grant_kind,
    input  logic signed [mul_pkg::op_a_width-1:0]   op_a_data [num_flows],
    input  logic signed [mul_pkg::coeff_width-1:0]  sel_coeff,
    input  logic                                    sel_last,
    output logic                                    prod_write,
    output logic [tag_width-1:0]                    prod_tag,
    output logic signed [mul_pkg::prod_width-1:0]   prod_data,
    output logic                                    prod_last
);

    logic signed [mul_pkg::op_a_width-1:0]  operand;
    logic signed [mul_pkg::prod_width-1:0]  operand_ext;
    logic signed [mul_pkg::prod_width-1:0]  coeff_ext;

    // sample of the flow being served
    assign operand = op_a_data[grant_tag];

    // sign extend both factors to the full product width first
    assign operand_ext = operand;
    assign coeff_ext   = sel_coeff;
    assign prod_data   = operand_ext * coeff_ext;

    assign prod_write = grant_valid && (grant_kind == mul_pkg::GRANT_MUL);
    assign prod_tag   = grant_tag;
    assign prod_last  = prod_write && sel_last;

endmodule

/* design/coeff_mul_top.sv */
// multi-flow coefficient multiplier sharing one 18x9 signed multiplier across flows
module coeff_mul_top #(
    parameter int num_flows = 2,
    localparam int tag_width = $clog2(num_flows)
) (
    input  logic                                    clk,
    input  logic                                    rst,

    // configuration queues
    input  logic [num_flows-1:0]                    cfg_empty,
    output logic [num_flows-1:0]                    cfg_read,
    input  logic signed [mul_pkg::coeff_width-1:0]  cfg_coeff [num_flows],
    input  logic [mul_pkg::size_width-1:0]          cfg_rows [num_flows],
    input  logic [mul_pkg::size_width-1:0]          cfg_cols [num_flows],

    // sample queues
    input  logic [num_flows-1:0]                    op_a_empty,
    output logic [num_flows-1:0]                    op_a_read,
    input  logic signed [mul_pkg::op_a_width-1:0]   op_a_data [num_flows],

    // output queues
    input  logic [num_flows-1:0]                    prod_full,
    output logic                                    prod_write,
    output logic [tag_width-1:0]                    prod_tag,
    output logic signed [mul_pkg::prod_width-1:0]   prod_data,
    output logic                                    prod_last
);

    logic                                    grant_valid;
    logic [tag_width-1:0]                    grant_tag;
    mul_pkg::grant_kind_e                    grant_kind;
    logic [num_flows-1:0]                    flow_busy;
    logic signed [mul_pkg::coeff_width-1:0]  sel_coeff;
    logic                                    sel_last;

    flow_arbiter #(
        .num_flows (num_flows)
    ) arbiter_i (
        .cfg_empty   (cfg_empty),
        .op_a_empty  (op_a_empty),
        .prod_full   (prod_full),
        .flow_busy   (flow_busy),
        .grant_valid (grant_valid),
        .grant_tag   (grant_tag),
        .grant_kind  (grant_kind),
        .cfg_read    (cfg_read),
        .op_a_read   (op_a_read)
    );

    flow_context #(
        .num_flows (num_flows)
    ) context_i (
        .clk         (clk),
        .rst         (rst),
        .grant_valid (grant_valid),
        .grant_tag   (grant_tag),
        .grant_kind  (grant_kind),
        .cfg_coeff   (cfg_coeff),
        .cfg_rows    (cfg_rows),
        .cfg_cols    (cfg_cols),
        .flow_busy   (flow_busy),
        .sel_coeff   (sel_coeff),
        .sel_last    (sel_last)
    );

    product_unit #(
        .num_flows (num_flows)
    ) product_i (
        .grant_valid (grant_valid),
        .grant_tag   (grant_tag),
        .grant_kind  (grant_kind),
        .op_a_data   (op_a_data),
        .sel_coeff   (sel_coeff),
        .sel_last    (sel_last),
        .prod_write  (prod_write),
        .prod_tag    (prod_tag),
        .prod_data   (prod_data),
        .prod_last   (prod_last)
    );

endmodule

/* sim/coeff_mul_checker.sv */
// protocol assertions on the queue handshakes of the coefficient multiplier
module coeff_mul_checker #(
    parameter int num_flows = 2,
    localparam int tag_width = $clog2(num_flows)
) (
    input logic                 clk,
    input logic                 rst,
    input logic [num_flows-1:0] cfg_empty,
    input logic [num_flows-1:0] cfg_read,
    input logic [num_flows-1:0] op_a_empty,
    input logic [num_flows-1:0] op_a_read,
    input logic [num_flows-1:0] prod_full,
    input logic                 prod_write,
    input logic [tag_width-1:0] prod_tag
);
    timeunit 1ns;
    timeprecision 1ps;

    // a product only goes to a queue with room
    write_room: assert property (@(posedge clk) disable iff (rst)
        prod_write |-> !prod_full[prod_tag])
        else $error("product write for flow %0d while its output queue is full", prod_tag);

    // at most one read strobe per cycle
    one_read: assert property (@(posedge clk) disable iff (rst)
        $onehot0({cfg_read, op_a_read}))
        else $error("more than one read strobe in one cycle");

    // never read an empty queue
    read_nonempty: assert property (@(posedge clk) disable iff (rst)
        ((cfg_read & cfg_empty) == '0) && ((op_a_read & op_a_empty) == '0))
        else $error("read strobe raised on an empty queue");

    // quiet during reset and in the first cycle after it
    reset_quiet: assert property (@(posedge clk)
        (rst || $past(rst)) |-> (cfg_read == '0 && op_a_read == '0 && !prod_write))
        else $error("strobe or write seen during or right after reset");

endmodule

bind coeff_mul_top coeff_mul_checker #(
    .num_flows (num_flows)
) checker_i (
    .clk        (clk),
    .rst        (rst),
    .cfg_empty  (cfg_empty),
    .cfg_read   (cfg_read),
    .op_a_empty (op_a_empty),
    .op_a_read  (op_a_read),
    .prod_full  (prod_full),
    .prod_write (prod_write),
    .prod_tag   (prod_tag)
);

/* sim/coeff_mul_tb.sv */
// testbench for the multi-flow coefficient multiplier with queue models and a product reference
module coeff_mul_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int num_flows = 2;
    localparam int tag_width = $clog2(num_flows);

    typedef struct packed {
        logic signed [mul_pkg::coeff_width-1:0] coeff;
        logic [mul_pkg::size_width-1:0]         rows;
        logic [mul_pkg::size_width-1:0]         cols;
    } cfg_word_t;

    // one expected product with its end-of-block flag
    typedef struct packed {
        logic                                  last;
        logic signed [mul_pkg::prod_width-1:0] data;
    } exp_t;

    logic                                    clk;
    logic                                    rst;
    logic [num_flows-1:0]                    cfg_empty;
    logic [num_flows-1:0]                    cfg_read;
    logic signed [mul_pkg::coeff_width-1:0]  cfg_coeff [num_flows];
    logic [mul_pkg::size_width-1:0]          cfg_rows [num_flows];
    logic [mul_pkg::size_width-1:0]          cfg_cols [num_flows];
    logic [num_flows-1:0]                    op_a_empty;
    logic [num_flows-1:0]                    op_a_read;
    logic signed [mul_pkg::op_a_width-1:0]   op_a_data [num_flows];
    logic [num_flows-1:0]                    prod_full;
    logic                                    prod_write;
    logic [tag_width-1:0]                    prod_tag;
    logic signed [mul_pkg::prod_width-1:0]   prod_data;
    logic                                    prod_last;

    // queues seen by the DUT
    cfg_word_t                              cfg_q [num_flows][$];
    logic signed [mul_pkg::op_a_width-1:0]  sample_q [num_flows][$];

    // issue-order model used to build the expected products
    cfg_word_t                              model_cfg_q [num_flows][$];
    logic signed [mul_pkg::op_a_width-1:0]  model_sample_q [num_flows][$];
    int                                     model_left [num_flows];
    logic signed [mul_pkg::coeff_width-1:0] model_coeff [num_flows];
    exp_t                                   exp_q [num_flows][$];

    // stall pattern per flow with 0 never full, 1 random and 2 held full
    int stall_mode [num_flows];
    int written [num_flows];
    int pushed_total;
    int cycle_count;

    coeff_mul_top #(
        .num_flows (num_flows)
    ) dut_i (
        .clk        (clk),
        .rst        (rst),
        .cfg_empty  (cfg_empty),
        .cfg_read   (cfg_read),
        .cfg_coeff  (cfg_coeff),
        .cfg_rows   (cfg_rows),
        .cfg_cols   (cfg_cols),
        .op_a_empty (op_a_empty),
        .op_a_read  (op_a_read),
        .op_a_data  (op_a_data),
        .prod_full  (prod_full),
        .prod_write (prod_write),
        .prod_tag   (prod_tag),
        .prod_data  (prod_data),
        .prod_last  (prod_last)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic signed [mul_pkg::prod_width-1:0] expected_product(
        input logic signed [mul_pkg::op_a_width-1:0]  sample,
        input logic signed [mul_pkg::coeff_width-1:0] coeff
    );
        longint full;
        full = longint'(sample) * longint'(coeff);
        return full[mul_pkg::prod_width-1:0];
    endfunction

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string name, input longint actual, input longint expected);
        if (actual != expected)
        begin
            $display("CHECK FAILED at %0t ns: %s is %0d, expected %0d",
                     $time, name, actual, expected);
            abort_run();
        end
    endtask

    // present the head of every queue to the DUT
    task automatic drive_queues();
        cfg_word_t w;
        for (int f = 0; f < num_flows; f++)
        begin
            w = '0;
            if (cfg_q[f].size() > 0)
                w = cfg_q[f][0];
            cfg_empty[f]  = (cfg_q[f].size() == 0);
            cfg_coeff[f]  = w.coeff;
            cfg_rows[f]   = w.rows;
            cfg_cols[f]   = w.cols;
            op_a_empty[f] = (sample_q[f].size() == 0);
            op_a_data[f]  = (sample_q[f].size() > 0) ? sample_q[f][0] : '0;
        end
    endtask

    // pair pushed samples with pushed configurations in issue order
    task automatic build_expected(input int f);
        cfg_word_t w;
        exp_t      e;
        while (model_sample_q[f].size() > 0 && (model_left[f] > 0 || model_cfg_q[f].size() > 0))
        begin
            if (model_left[f] == 0)
            begin
                w = model_cfg_q[f].pop_front();
                model_coeff[f] = w.coeff;
                model_left[f]  = int'(w.rows) * int'(w.cols);
            end
            model_left[f]--;
            e.last = (model_left[f] == 0);
            e.data = expected_product(model_sample_q[f].pop_front(), model_coeff[f]);
            exp_q[f].push_back(e);
        end
    endtask

    task automatic push_cfg(input int f, input logic signed [mul_pkg::coeff_width-1:0] coeff,
                            input int rows, input int cols);
        cfg_word_t w;
        w.coeff = coeff;
        w.rows  = mul_pkg::size_width'(rows);
        w.cols  = mul_pkg::size_width'(cols);
        cfg_q[f].push_back(w);
        model_cfg_q[f].push_back(w);
        build_expected(f);
        drive_queues();
    endtask

    task automatic push_sample(input int f, input logic signed [mul_pkg::op_a_width-1:0] s);
        sample_q[f].push_back(s);
        model_sample_q[f].push_back(s);
        pushed_total++;
        build_expected(f);
        drive_queues();
    endtask

    task automatic push_block(input int f, input logic signed [mul_pkg::coeff_width-1:0] coeff,
                              input int rows, input int cols);
        push_cfg(f, coeff, rows, cols);
        for (int k = 0; k < rows * cols; k++)
            push_sample(f, mul_pkg::op_a_width'($urandom()));
    endtask

    // one clock with strobes taken at the edge and queues and stalls updated just after it
    task automatic step();
        logic [num_flows-1:0] cfg_taken;
        logic [num_flows-1:0] op_taken;
        @(posedge clk);
        cfg_taken = cfg_read;
        op_taken  = op_a_read;
        #1;
        for (int f = 0; f < num_flows; f++)
        begin
            if (cfg_taken[f] && cfg_q[f].size() > 0)
                void'(cfg_q[f].pop_front());
            if (op_taken[f] && sample_q[f].size() > 0)
                void'(sample_q[f].pop_front());
            if (stall_mode[f] == 2)
                prod_full[f] = 1'b1;
            else if (stall_mode[f] == 1)
                prod_full[f] = (($urandom() % 32'd3) == 32'd0);
            else
                prod_full[f] = 1'b0;
        end
        drive_queues();
    endtask

    task automatic run_cycles(input int n);
        repeat (n) step();
    endtask

    task automatic wait_drain();
        while (exp_q[0].size() + exp_q[1].size() > 0)
            step();
    endtask

    task automatic compare_write();
        exp_t e;
        int   tag;
        tag = int'(prod_tag);
        if (exp_q[tag].size() == 0)
        begin
            $display("product write for flow %0d at %0t ns with no product expected", tag, $time);
            abort_run();
        end
        else
        begin
            e = exp_q[tag].pop_front();
            check_value("prod_data", longint'(prod_data), longint'(e.data));
            check_value("prod_last", longint'(prod_last), longint'(e.last));
            written[tag]++;
        end
    endtask

    always @(posedge clk)
    begin
        if (!rst && prod_write)
            compare_write();
    end

    // limit grows with the number of samples pushed so far
    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count > 4 * pushed_total + 200)
        begin
            $display("timeout after %0d cycles with products still outstanding", cycle_count);
            abort_run();
        end
    end

    initial
    begin
        int before0;
        int before1;
        int leftover;
        void'($urandom(32'hd37b));
        rst          = 1'b1;
        prod_full    = '0;
        pushed_total = 0;
        cycle_count  = 0;
        for (int f = 0; f < num_flows; f++)
        begin
            stall_mode[f]  = 0;
            written[f]     = 0;
            model_left[f]  = 0;
            model_coeff[f] = '0;
        end
        drive_queues();
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        run_cycles(2);

        // single flow of 3 rows by 4 columns
        push_block(0, -9'sd37, 3, 4);
        // one load and twelve multiplies at one action per cycle
        run_cycles(13);
        check_value("flow 0 product count", written[0], 12);
        wait_drain();

        // early samples wait for the reconfigured coefficient
        push_block(0, 9'sd3, 2, 2);
        wait_drain();
        for (int k = 0; k < 3; k++)
            push_sample(0, mul_pkg::op_a_width'($urandom()));
        run_cycles(8);
        check_value("flow 0 waiting samples", sample_q[0].size(), 3);
        push_cfg(0, -9'sd100, 1, 3);
        wait_drain();

        // two flows with interleaved pushes
        push_cfg(0, 9'sd77, 2, 3);
        push_cfg(1, -9'sd19, 3, 2);
        for (int k = 0; k < 6; k++)
        begin
            push_sample(0, mul_pkg::op_a_width'($urandom()));
            push_sample(1, mul_pkg::op_a_width'($urandom()));
            step();
        end
        stall_mode[0] = 1;
        stall_mode[1] = 1;
        push_block(0, 9'sd101, 1, 5);
        push_block(1, -9'sd200, 2, 2);
        wait_drain();
        stall_mode[0] = 0;
        stall_mode[1] = 0;

        // flow 1 held full while flow 0 keeps going
        stall_mode[1] = 2;
        before0 = written[0];
        before1 = written[1];
        push_block(1, 9'sd11, 2, 3);
        push_block(0, -9'sd5, 2, 4);
        run_cycles(20);
        check_value("flow 1 queued samples", sample_q[1].size(), 6);
        check_value("flow 1 products while full", written[1] - before1, 0);
        check_value("flow 0 products while flow 1 full", written[0] - before0, 8);
        stall_mode[1] = 0;
        wait_drain();

        // signed extremes in 1x1 blocks where 9'sh100 is -256
        push_cfg(0, 9'sh100, 1, 1);
        push_sample(0, 18'sh20000);
        push_cfg(0, 9'sd255, 1, 1);
        push_sample(0, 18'sh1ffff);
        push_cfg(0, 9'sh100, 1, 1);
        push_sample(0, 18'sh1ffff);
        push_cfg(0, 9'sd255, 1, 1);
        push_sample(0, 18'sh20000);
        push_cfg(1, -9'sd1, 1, 1);
        push_sample(1, 18'sh20000);
        wait_drain();
        run_cycles(4);

        leftover = 0;
        for (int f = 0; f < num_flows; f++)
            leftover += cfg_q[f].size() + sample_q[f].size() + exp_q[f].size();
        if (leftover != 0)
        begin
            $display("run ended with %0d queue entries left over", leftover);
            abort_run();
        end
        else
        begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

/* files.f */
design/mul_pkg.sv
design/flow_arbiter.sv
design/flow_context.sv
design/product_unit.sv
design/coeff_mul_top.sv
sim/coeff_mul_checker.sv
sim/coeff_mul_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the coefficient multiplier testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module coeff_mul_tb -f files.f -o coeff_mul_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/coeff_mul_sim > sim.log 2>&1

grep -qF '*** TEST PASSED ***' sim.log \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed, see sim.log"; exit 1; }
